/* hdl/cpuPkg.sv */
`default_nettype none

package cpuPkg;

  // --------------------
  // sizes
  localparam int dataW    = 32;
  localparam int regAddrW = 5;
  localparam int memDepth = 64;
  localparam int memAddrW = 6;  // log2 of memDepth

  // --------------------
  // instruction encodings
  localparam logic [5:0] opR    = 6'h00;
  localparam logic [5:0] opJ    = 6'h02;
  localparam logic [5:0] opBeq  = 6'h04;
  localparam logic [5:0] opBne  = 6'h05;
  localparam logic [5:0] opAddi = 6'h08;
  localparam logic [5:0] opLw   = 6'h23;
  localparam logic [5:0] opSw   = 6'h2b;
  localparam logic [5:0] opHalt = 6'h3f;  // all ones

  localparam logic [5:0] fnAdd = 6'h20;   // R-type function field
  localparam logic [5:0] fnSub = 6'h22;
  localparam logic [5:0] fnAnd = 6'h24;
  localparam logic [5:0] fnOr  = 6'h25;
  localparam logic [5:0] fnSlt = 6'h2a;

  typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOr, aluSlt} aluOpT;

  // operand source in EX
  typedef enum logic [1:0] {fwdReg, fwdMem, fwdWb} fwdSelT;

  // --------------------
  // stage payloads
  typedef struct packed {
    logic [dataW-1:0]    rsVal;
    logic [dataW-1:0]    rtVal;
    logic [dataW-1:0]    imm;     // already sign extended
    logic [regAddrW-1:0] rs;
    logic [regAddrW-1:0] rt;
    logic [regAddrW-1:0] rd;      // R-type destination field
    aluOpT               aluOp;
    logic                useImm;  // also selects rt as destination
    logic                memRead;
    logic                memWrite;
    logic                regWrite;
    logic                halt;
  } idExT;

  typedef struct packed {
    logic [dataW-1:0]    aluRes;     // data address on lw and sw
    logic [dataW-1:0]    storeData;
    logic [regAddrW-1:0] rd;
    logic                memRead;
    logic                memWrite;
    logic                regWrite;
    logic                halt;
  } exMemT;

  typedef struct packed {
    logic [dataW-1:0]    wbVal;
    logic [regAddrW-1:0] rd;
    logic                regWrite;
    logic                halt;
  } memWbT;

  // debug map, byte addresses on the 12-bit wishbone bus
  typedef logic [11:0] dbgAddrT;

  localparam dbgAddrT dbgImemBase = 12'h000;
  localparam dbgAddrT dbgRegBase  = 12'h100;
  localparam dbgAddrT dbgDmemBase = 12'h200;
  localparam dbgAddrT dbgCtrl     = 12'h300;  // wr bit0 run, rd {run, halted}
  localparam dbgAddrT dbgCycles   = 12'h304;

endpackage

`default_nettype wire

/* hdl/pipeReg.sv */
`timescale 1ns/1ps
`default_nettype none

// stage register that loads an all-zero bubble on reset or flush
module pipeReg #(
  parameter type payloadT = logic
) (
  input  wire logic    clk,
  input  wire logic    arstN,
  input  wire logic    en,     // low holds the payload
  input  wire logic    flush,  // wins over en
  input  wire payloadT d,
  output payloadT      q
);

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      q <= '0;
    end else if (flush) begin
      q <= '0;
    end else if (en) begin
      q <= d;
    end
  end

endmodule

`default_nettype wire

/* hdl/fetchStage.sv */
`timescale 1ns/1ps
`default_nettype none

module fetchStage (
  input  wire logic                        clk,
  input  wire logic                        arstN,
  input  wire logic                        run,
  input  wire logic                        stall,
  input  wire logic                        redirect,
  input  wire logic [cpuPkg::dataW-1:0]    target,
  input  wire logic                        haltSeen,
  input  wire logic                        imemWe,
  input  wire logic [cpuPkg::memAddrW-1:0] imemAddr,
  input  wire logic [cpuPkg::dataW-1:0]    imemData,
  output logic [cpuPkg::dataW-1:0]         instr,
  output logic [cpuPkg::dataW-1:0]         pcPlus4
);

  logic [cpuPkg::dataW-1:0] pc;
  logic [cpuPkg::dataW-1:0] imem [cpuPkg::memDepth];  // program store

  assign pcPlus4 = pc + 4;
  assign instr   = imem[pc[cpuPkg::memAddrW+1:2]];  // async read by word index

  // next pc: redirect target, then pc+4, else hold
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      pc <= '0;
    end else if (redirect) begin
      pc <= target;  // taken branch or jump from decode
    end else if (run && !stall && !haltSeen) begin
      pc <= pcPlus4;
    end
  end

  // only the debug port writes here
  always_ff @(posedge clk) begin
    if (imemWe) begin
      imem[imemAddr] <= imemData;
    end
  end

endmodule

`default_nettype wire

/* hdl/regFile.sv */
`timescale 1ns/1ps
`default_nettype none

module regFile (
  input  wire logic                        clk,
  input  wire logic                        arstN,
  input  wire logic [cpuPkg::regAddrW-1:0] rs,
  input  wire logic [cpuPkg::regAddrW-1:0] rt,
  output logic [cpuPkg::dataW-1:0]         rsData,
  output logic [cpuPkg::dataW-1:0]         rtData,
  input  wire cpuPkg::memWbT               wb,       // write port from MEM/WB
  input  wire logic [cpuPkg::regAddrW-1:0] dbgIdx,
  output logic [cpuPkg::dataW-1:0]         dbgData
);

  logic [cpuPkg::dataW-1:0] regs [2**cpuPkg::regAddrW];

  // falling edge write so decode sees the value in the same cycle
  always_ff @(negedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < 2**cpuPkg::regAddrW; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.regWrite && wb.rd != '0) begin
      regs[wb.rd] <= wb.wbVal;  // r0 never written so it stays zero
    end
  end

  assign rsData  = regs[rs];
  assign rtData  = regs[rt];
  assign dbgData = regs[dbgIdx];

endmodule

`default_nettype wire

/* hdl/decodeStage.sv */
`timescale 1ns/1ps
`default_nettype none

module decodeStage (
  input  wire logic [2*cpuPkg::dataW-1:0]  ifId,  // {instr, pcPlus4}
  input  wire logic                        run,
  input  wire logic [cpuPkg::dataW-1:0]    rsData,
  input  wire logic [cpuPkg::dataW-1:0]    rtData,
  output logic [cpuPkg::regAddrW-1:0]      rs,
  output logic [cpuPkg::regAddrW-1:0]      rt,
  input  wire cpuPkg::idExT                exIn,
  input  wire cpuPkg::exMemT               memIn,
  input  wire cpuPkg::memWbT               wbIn,
  output logic                             stall,
  output logic                             redirect,
  output logic [cpuPkg::dataW-1:0]         target,
  output logic                             haltSeen,
  output cpuPkg::idExT                     idEx
);

  logic [cpuPkg::dataW-1:0]    instr;
  logic [cpuPkg::dataW-1:0]    pcPlus4;
  logic [5:0]                  opcode;
  logic [5:0]                  funct;
  logic [cpuPkg::dataW-1:0]    imm;
  logic [cpuPkg::regAddrW-1:0] exDst;
  logic [cpuPkg::dataW-1:0]    rsCmp;
  logic [cpuPkg::dataW-1:0]    rtCmp;
  logic                        usesRs;
  logic                        usesRt;
  logic                        isBranch;
  logic                        isJump;
  logic                        loadUse;
  logic                        brOnAlu;
  logic                        brOnLoad;
  logic                        taken;
  cpuPkg::idExT                ctl;

  // comparator operand, newest producer first
  function automatic logic [cpuPkg::dataW-1:0] brFwd(
    input logic [cpuPkg::regAddrW-1:0] idx,
    input logic [cpuPkg::dataW-1:0]    regVal,
    input cpuPkg::exMemT               m,
    input cpuPkg::memWbT               w
  );
    if (m.regWrite && m.rd != '0 && m.rd == idx) begin
      return m.aluRes;
    end
    if (w.regWrite && w.rd != '0 && w.rd == idx) begin
      return w.wbVal;
    end
    return regVal;
  endfunction

  // --------------------
  // fields
  assign {instr, pcPlus4} = ifId;
  assign opcode = instr[31:26];
  assign rs     = instr[25:21];
  assign rt     = instr[20:16];
  assign funct  = instr[5:0];
  assign imm    = {{(cpuPkg::dataW-16){instr[15]}}, instr[15:0]};

  always_comb begin
    ctl      = '0;
    usesRs   = 1'b0;
    usesRt   = 1'b0;
    isBranch = 1'b0;
    isJump   = 1'b0;
    case (opcode)
      cpuPkg::opR: begin
        usesRs       = 1'b1;
        usesRt       = 1'b1;
        ctl.regWrite = 1'b1;
        case (funct)
          cpuPkg::fnAdd: ctl.aluOp = cpuPkg::aluAdd;
          cpuPkg::fnSub: ctl.aluOp = cpuPkg::aluSub;
          cpuPkg::fnAnd: ctl.aluOp = cpuPkg::aluAnd;
          cpuPkg::fnOr:  ctl.aluOp = cpuPkg::aluOr;
          cpuPkg::fnSlt: ctl.aluOp = cpuPkg::aluSlt;
          default:       ctl.regWrite = 1'b0;  // unknown funct acts as nop
        endcase
      end
      cpuPkg::opAddi: begin
        usesRs       = 1'b1;
        ctl.useImm   = 1'b1;
        ctl.regWrite = 1'b1;
      end
      cpuPkg::opLw: begin
        usesRs       = 1'b1;
        ctl.useImm   = 1'b1;
        ctl.memRead  = 1'b1;
        ctl.regWrite = 1'b1;
      end
      cpuPkg::opSw: begin
        usesRs       = 1'b1;
        usesRt       = 1'b1;  // store data
        ctl.useImm   = 1'b1;
        ctl.memWrite = 1'b1;
      end
      cpuPkg::opBeq, cpuPkg::opBne: begin
        usesRs   = 1'b1;
        usesRt   = 1'b1;
        isBranch = 1'b1;
      end
      cpuPkg::opJ:    isJump   = 1'b1;
      cpuPkg::opHalt: ctl.halt = 1'b1;
      default: ;  // reserved opcode issues as nop
    endcase
    ctl.rsVal = rsData;
    ctl.rtVal = rtData;
    ctl.imm   = imm;
    ctl.rs    = rs;
    ctl.rt    = rt;
    ctl.rd    = instr[15:11];
  end

  // --------------------
  // hazards
  assign exDst   = exIn.useImm ? exIn.rt : exIn.rd;  // same choice as execute
  assign loadUse = exIn.memRead && exDst != '0
                   && ((usesRs && exDst == rs) || (usesRt && exDst == rt));
  // EX result not ready for the comparator yet
  assign brOnAlu  = isBranch && exIn.regWrite && exDst != '0
                    && (exDst == rs || exDst == rt);
  // load data is only known after MEM
  assign brOnLoad = isBranch && memIn.memRead && memIn.rd != '0
                    && (memIn.rd == rs || memIn.rd == rt);
  assign stall    = run && (loadUse || brOnAlu || brOnLoad);

  // --------------------
  // branch and jump
  assign rsCmp    = brFwd(rs, rsData, memIn, wbIn);
  assign rtCmp    = brFwd(rt, rtData, memIn, wbIn);
  assign taken    = (opcode == cpuPkg::opBne) ? (rsCmp != rtCmp) : (rsCmp == rtCmp);
  assign redirect = run && !stall && (isJump || (isBranch && taken));
  assign target   = isJump ? {pcPlus4[cpuPkg::dataW-1:cpuPkg::dataW-4], instr[25:0], 2'b00}
                           : pcPlus4 + (imm << 2);
  assign haltSeen = run && ctl.halt;  // pc and IF/ID freeze from here on

  assign idEx = (run && !stall) ? ctl : '0;  // bubble when held

endmodule

`default_nettype wire

/* hdl/executeStage.sv */
`timescale 1ns/1ps
`default_nettype none

module executeStage (
  input  wire cpuPkg::idExT  idEx,
  input  wire cpuPkg::exMemT memFwd,  // fwdMem source
  input  wire cpuPkg::memWbT wbFwd,   // fwdWb source
  output cpuPkg::exMemT      exMem
);

  cpuPkg::fwdSelT           selA;
  cpuPkg::fwdSelT           selB;
  logic [cpuPkg::dataW-1:0] opA;
  logic [cpuPkg::dataW-1:0] opB;
  logic [cpuPkg::dataW-1:0] aluB;
  logic [cpuPkg::dataW-1:0] aluRes;

  // EX/MEM is newer so it wins over MEM/WB
  function automatic cpuPkg::fwdSelT pickSrc(
    input logic [cpuPkg::regAddrW-1:0] idx,
    input cpuPkg::exMemT               m,
    input cpuPkg::memWbT               w
  );
    if (m.regWrite && m.rd != '0 && m.rd == idx) begin
      return cpuPkg::fwdMem;
    end
    if (w.regWrite && w.rd != '0 && w.rd == idx) begin
      return cpuPkg::fwdWb;
    end
    return cpuPkg::fwdReg;
  endfunction

  assign selA = pickSrc(idEx.rs, memFwd, wbFwd);
  assign selB = pickSrc(idEx.rt, memFwd, wbFwd);

  always_comb begin
    case (selA)
      cpuPkg::fwdMem: opA = memFwd.aluRes;
      cpuPkg::fwdWb:  opA = wbFwd.wbVal;
      default:        opA = idEx.rsVal;
    endcase
    case (selB)
      cpuPkg::fwdMem: opB = memFwd.aluRes;
      cpuPkg::fwdWb:  opB = wbFwd.wbVal;
      default:        opB = idEx.rtVal;
    endcase
  end

  assign aluB = idEx.useImm ? idEx.imm : opB;

  // --------------------
  // ALU
  always_comb begin
    case (idEx.aluOp)
      cpuPkg::aluSub: aluRes = opA - aluB;
      cpuPkg::aluAnd: aluRes = opA & aluB;
      cpuPkg::aluOr:  aluRes = opA | aluB;
      cpuPkg::aluSlt: aluRes = {{(cpuPkg::dataW-1){1'b0}}, $signed(opA) < $signed(aluB)};
      default:        aluRes = opA + aluB;  // add, lw and sw address
    endcase
  end

  assign exMem = '{
    aluRes:    aluRes,
    storeData: opB,                                  // forwarded store value
    rd:        idEx.useImm ? idEx.rt : idEx.rd,      // I-type writes rt
    memRead:   idEx.memRead,
    memWrite:  idEx.memWrite,
    regWrite:  idEx.regWrite,
    halt:      idEx.halt
  };

endmodule

`default_nettype wire

/* hdl/memStage.sv */
`timescale 1ns/1ps
`default_nettype none

module memStage (
  input  wire logic                        clk,
  input  wire logic                        arstN,
  input  wire cpuPkg::exMemT               exMem,
  output cpuPkg::memWbT                    memWb,   // MEM/WB register
  input  wire logic [cpuPkg::memAddrW-1:0] dbgIdx,
  output logic [cpuPkg::dataW-1:0]         dbgData
);

  logic [cpuPkg::dataW-1:0]    dmem [cpuPkg::memDepth];
  logic [cpuPkg::memAddrW-1:0] wordIdx;
  cpuPkg::memWbT               wbNext;

  assign wordIdx = exMem.aluRes[cpuPkg::memAddrW+1:2];  // byte address to word

  always_ff @(posedge clk) begin
    if (exMem.memWrite) begin
      dmem[wordIdx] <= exMem.storeData;
    end
  end

  assign dbgData = dmem[dbgIdx];

  // load data or ALU result
  assign wbNext = '{
    wbVal:    exMem.memRead ? dmem[wordIdx] : exMem.aluRes,
    rd:       exMem.rd,
    regWrite: exMem.regWrite,
    halt:     exMem.halt
  };

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      memWb <= '0;
    end else begin
      memWb <= wbNext;
    end
  end

endmodule

`default_nettype wire

/* hdl/debugPort.sv */
`timescale 1ns/1ps
`default_nettype none

module debugPort (
  input  wire logic                        clk,
  input  wire logic                        arstN,
  input  wire logic                        wbCyc,
  input  wire logic                        wbStb,
  input  wire logic                        wbWe,
  input  wire logic [11:0]                 wbAdr,
  input  wire logic [cpuPkg::dataW-1:0]    wbDatW,
  output logic [cpuPkg::dataW-1:0]         wbDatR,
  output logic                             wbAck,
  input  wire logic                        wbHalt,  // halt flag at MEM/WB
  input  wire logic [cpuPkg::dataW-1:0]    regDbg,
  input  wire logic [cpuPkg::dataW-1:0]    memDbg,
  output logic [cpuPkg::memAddrW-1:0]      dbgIdx,
  output logic                             imemWe,
  output logic [cpuPkg::memAddrW-1:0]      imemAddr,
  output logic [cpuPkg::dataW-1:0]         imemData,
  output logic                             run
);

  logic                     req;
  logic                     halted;
  logic [3:0]               region;
  logic [cpuPkg::dataW-1:0] cycles;

  assign req      = wbCyc && wbStb && !wbAck;  // new transfer, one cycle only
  assign region   = wbAdr[11:8];
  assign dbgIdx   = wbAdr[cpuPkg::memAddrW+1:2];
  assign imemAddr = wbAdr[cpuPkg::memAddrW+1:2];
  assign imemData = wbDatW;
  assign imemWe   = req && wbWe && !run && region == cpuPkg::dbgImemBase[11:8];

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      wbAck  <= 1'b0;
      run    <= 1'b0;
      halted <= 1'b0;
      cycles <= '0;
    end else begin
      wbAck <= req;
      if (req && wbWe && wbAdr == cpuPkg::dbgCtrl && wbDatW[0]) begin
        run <= 1'b1;  // set only, cleared by reset
      end
      halted <= halted || wbHalt;
      if (run && !halted) begin
        cycles <= cycles + 1;
      end
    end
  end

  // --------------------
  // read data, address is held until ack
  always_comb begin
    wbDatR = '0;  // imem and unmapped read as zero
    if (region == cpuPkg::dbgRegBase[11:8]) begin
      wbDatR = regDbg;
    end else if (region == cpuPkg::dbgDmemBase[11:8]) begin
      wbDatR = memDbg;
    end else if (wbAdr == cpuPkg::dbgCycles) begin
      wbDatR = cycles;
    end else if (wbAdr == cpuPkg::dbgCtrl) begin
      wbDatR = {{(cpuPkg::dataW-2){1'b0}}, run, halted};
    end
  end

endmodule

`default_nettype wire

/* hdl/cpuTop.sv */
`timescale 1ns/1ps
`default_nettype none

module cpuTop (
  input  wire logic                     clk,
  input  wire logic                     arstN,
  input  wire logic                     wbCyc,
  input  wire logic                     wbStb,
  input  wire logic                     wbWe,
  input  wire logic [11:0]              wbAdr,
  input  wire logic [cpuPkg::dataW-1:0] wbDatW,
  output logic [cpuPkg::dataW-1:0]      wbDatR,
  output logic                          wbAck
);

  logic [2*cpuPkg::dataW-1:0]  ifIdQ;
  logic [cpuPkg::dataW-1:0]    instr;
  logic [cpuPkg::dataW-1:0]    pcPlus4;
  logic [cpuPkg::dataW-1:0]    target;
  logic [cpuPkg::dataW-1:0]    rsData;
  logic [cpuPkg::dataW-1:0]    rtData;
  logic [cpuPkg::dataW-1:0]    regDbg;
  logic [cpuPkg::dataW-1:0]    memDbg;
  logic [cpuPkg::dataW-1:0]    imemData;
  logic [cpuPkg::regAddrW-1:0] rs;
  logic [cpuPkg::regAddrW-1:0] rt;
  logic [cpuPkg::memAddrW-1:0] dbgIdx;
  logic [cpuPkg::memAddrW-1:0] imemAddr;
  logic                        run;
  logic                        stall;
  logic                        redirect;
  logic                        haltSeen;
  logic                        imemWe;
  cpuPkg::idExT                idExD;
  cpuPkg::idExT                idExQ;
  cpuPkg::exMemT               exMemD;
  cpuPkg::exMemT               exMemQ;
  cpuPkg::memWbT               memWbQ;

  // --------------------
  // IF
  fetchStage fetch (
    .clk, .arstN, .run, .stall, .redirect, .target, .haltSeen,
    .imemWe, .imemAddr, .imemData, .instr, .pcPlus4
  );

  // bubble until run, held on stall or halt, emptied by a redirect
  pipeReg #(.payloadT(logic [2*cpuPkg::dataW-1:0])) ifIdReg (
    .clk, .arstN,
    .en    (run && !(stall || haltSeen)),
    .flush (redirect),
    .d     ({instr, pcPlus4}),
    .q     (ifIdQ)
  );

  // --------------------
  // ID
  regFile regs (
    .clk, .arstN, .rs, .rt, .rsData, .rtData,
    .wb      (memWbQ),
    .dbgIdx  (dbgIdx[cpuPkg::regAddrW-1:0]),
    .dbgData (regDbg)
  );

  decodeStage decode (
    .ifId  (ifIdQ),
    .run, .rsData, .rtData, .rs, .rt,
    .exIn  (idExQ),
    .memIn (exMemQ),
    .wbIn  (memWbQ),
    .stall, .redirect, .target, .haltSeen,
    .idEx  (idExD)
  );

  pipeReg #(.payloadT(cpuPkg::idExT)) idExReg (
    .clk, .arstN, .en(1'b1), .flush(1'b0), .d(idExD), .q(idExQ)
  );

  // --------------------
  // EX and MEM
  executeStage execute (
    .idEx   (idExQ),
    .memFwd (exMemQ),
    .wbFwd  (memWbQ),
    .exMem  (exMemD)
  );

  pipeReg #(.payloadT(cpuPkg::exMemT)) exMemReg (
    .clk, .arstN, .en(1'b1), .flush(1'b0), .d(exMemD), .q(exMemQ)
  );

  memStage mem (
    .clk, .arstN,
    .exMem   (exMemQ),
    .memWb   (memWbQ),
    .dbgIdx,
    .dbgData (memDbg)
  );

  debugPort debug (
    .clk, .arstN, .wbCyc, .wbStb, .wbWe, .wbAdr, .wbDatW, .wbDatR, .wbAck,
    .wbHalt (memWbQ.halt),
    .regDbg, .memDbg, .dbgIdx, .imemWe, .imemAddr, .imemData, .run
  );

endmodule

`default_nettype wire

/* testbench/cpuTb.sv */
`timescale 1ns/1ps
`default_nettype none

module cpuTb;

  localparam int ackLimit   = 20;    // cycles one transfer may wait for ack
  localparam int haltLimit  = 2000;  // cycles the program may take to halt
  localparam int counterGap = 25;    // idle cycles between the two counter reads

  logic                     clk;
  logic                     arstN;
  logic                     wbCyc;
  logic                     wbStb;
  logic                     wbWe;
  logic [11:0]              wbAdr;
  logic [cpuPkg::dataW-1:0] wbDatW;
  logic [cpuPkg::dataW-1:0] wbDatR;
  logic                     wbAck;
  int                       cycleNow = 0;  // free-running tb cycle count
  logic                     haltDone = 1'b0;

  cpuTop dut (
    .clk, .arstN, .wbCyc, .wbStb, .wbWe, .wbAdr, .wbDatW, .wbDatR, .wbAck
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;  // 10 ns period
  end

  always @(posedge clk) cycleNow <= cycleNow + 1;

  // --------------------
  // reporting and compares
  task automatic stopWithFailure(input string why);
    $display("%s", why);
    $display("CHECKS FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic checkWord(input string name, input logic [cpuPkg::dataW-1:0] got,
                           input logic [cpuPkg::dataW-1:0] exp);
    if (got !== exp) begin
      stopWithFailure($sformatf("CHECK FAILED %s: got 0x%08h expected 0x%08h", name, got, exp));
    end
  endtask

  task automatic checkFlag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stopWithFailure($sformatf("CHECK FAILED %s: got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  // byte address of word idx inside a debug region
  function automatic logic [11:0] regionAdr(input cpuPkg::dbgAddrT base,
                                            input logic [31:0] idx);
    return base + {idx[9:0], 2'b00};
  endfunction

  // --------------------
  // wishbone master, called on a falling edge and returns on one
  task automatic wbWrite(input logic [11:0] adr, input logic [cpuPkg::dataW-1:0] dat);
    int waited;
    waited = 0;
    wbCyc  = 1'b1;
    wbStb  = 1'b1;
    wbWe   = 1'b1;
    wbAdr  = adr;
    wbDatW = dat;
    @(negedge clk);
    while (wbAck !== 1'b1) begin  // slave acks one cycle later
      waited++;
      if (waited > ackLimit) begin
        stopWithFailure($sformatf("no ack for the write to address 0x%03h", adr));
      end
      @(negedge clk);
    end
    wbCyc = 1'b0;
    wbStb = 1'b0;
    wbWe  = 1'b0;
  endtask

  task automatic wbRead(input logic [11:0] adr, output logic [cpuPkg::dataW-1:0] dat);
    int waited;
    waited = 0;
    wbCyc  = 1'b1;
    wbStb  = 1'b1;
    wbWe   = 1'b0;
    wbAdr  = adr;
    @(negedge clk);
    while (wbAck !== 1'b1) begin
      waited++;
      if (waited > ackLimit) begin
        stopWithFailure($sformatf("no ack for the read from address 0x%03h", adr));
      end
      @(negedge clk);
    end
    dat   = wbDatR;  // valid while ack is high
    wbCyc = 1'b0;
    wbStb = 1'b0;
  endtask

  // --------------------
  // halt and cycle counter
  task automatic waitHalted();
    int                       start;
    logic [cpuPkg::dataW-1:0] status;
    start  = cycleNow;
    status = '0;
    while (status[0] !== 1'b1) begin  // bit 0 is halted
      if (cycleNow - start > haltLimit) begin
        stopWithFailure("the program did not halt within 2000 cycles");
      end
      wbRead(cpuPkg::dbgCtrl, status);
    end
  endtask

  task automatic checkCounter();
    logic [cpuPkg::dataW-1:0] first;
    logic [cpuPkg::dataW-1:0] second;
    logic [cpuPkg::dataW-1:0] status;
    wbRead(cpuPkg::dbgCycles, first);
    repeat (counterGap) @(negedge clk);
    wbRead(cpuPkg::dbgCycles, second);
    wbRead(cpuPkg::dbgCtrl, status);
    checkFlag("halted", status[0], 1'b1);
    checkFlag("run", status[1], 1'b1);
    if (first == '0) begin
      stopWithFailure("the cycle counter reads zero after halt");
    end
    checkWord("cycles", second, first);  // frozen once halted
  endtask

  // --------------------
  // stimulus file interpreter
  initial begin
    int                       fd;
    int                       n;
    logic [7:0]               cmd;
    logic [31:0]              argA;
    logic [31:0]              argB;
    logic [cpuPkg::dataW-1:0] got;
    logic [8*120-1:0]         rest;
    arstN  = 1'b0;
    wbCyc  = 1'b0;
    wbStb  = 1'b0;
    wbWe   = 1'b0;
    wbAdr  = '0;
    wbDatW = '0;
    repeat (10) @(negedge clk);
    arstN = 1'b1;
    @(negedge clk);
    fd = $fopen("testbench/cpuStim.txt", "r");
    if (fd == 0) begin
      stopWithFailure("cannot open testbench/cpuStim.txt");
    end
    while (!$feof(fd)) begin
      n = $fscanf(fd, " %c", cmd);
      if (n == 1) begin
        case (cmd)
          "#": n = $fgets(rest, fd);  // comment to end of line
          "G": wbWrite(cpuPkg::dbgCtrl, 32'h1);
          "H": begin
            waitHalted();
            checkCounter();
            haltDone = 1'b1;
          end
          "P", "R", "M": begin
            n = $fscanf(fd, " %h %h", argA, argB);
            if (n != 2) begin
              stopWithFailure("a line of the stimulus file lacks its two hex fields");
            end
            if (cmd == "P") begin
              wbWrite(regionAdr(cpuPkg::dbgImemBase, argA), argB);
            end else if (cmd == "R") begin
              wbRead(regionAdr(cpuPkg::dbgRegBase, argA), got);
              checkWord($sformatf("reg[%0d]", argA), got, argB);
            end else begin
              wbRead(regionAdr(cpuPkg::dbgDmemBase, argA), got);
              checkWord($sformatf("dmem[%0d]", argA), got, argB);
            end
          end
          default: stopWithFailure($sformatf("unknown command %c in stimulus file", cmd));
        endcase
      end
    end
    $fclose(fd);
    if (!haltDone) begin
      stopWithFailure("the stimulus file never waited for halt");
    end else begin
      $display("ALL CHECKS PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* testbench/cpuStim.txt */
# P word-index instruction | G run | H wait for halt | R reg value | M dmem-word value
# all numbers hex, text after # is ignored
P 00 20010005  # addi r1, r0, 5
P 01 2002FFFD  # addi r2, r0, -3
P 02 00221820  # add  r3, r1, r2
P 03 00222022  # sub  r4, r1, r2
P 04 00222824  # and  r5, r1, r2
P 05 00223025  # or   r6, r1, r2
P 06 0041382A  # slt  r7, r2, r1
P 07 0022402A  # slt  r8, r1, r2
P 08 20000007  # addi r0, r0, 7
P 09 20090001  # addi r9, r0, 1
P 0A 01294820  # add  r9, r9, r9
P 0B 01294820  # add  r9, r9, r9
P 0C 01215020  # add  r10, r9, r1
P 0D 200B000A  # addi r11, r0, 10
P 0E 01496020  # add  r12, r10, r9
P 0F AC0C0008  # sw   r12, 8(r0)
P 10 AC06000C  # sw   r6, 12(r0)
P 11 8C0D0008  # lw   r13, 8(r0)
P 12 01A17020  # add  r14, r13, r1
P 13 8C0F000C  # lw   r15, 12(r0)
P 14 AC0E0010  # sw   r14, 16(r0)
P 15 10210001  # beq  r1, r1, +1
P 16 20100001  # addi r16, r0, 1
P 17 14210001  # bne  r1, r1, +1
P 18 20110002  # addi r17, r0, 2
P 19 0800001B  # j    0x1b
P 1A 20120003  # addi r18, r0, 3
P 1B 2013000A  # addi r19, r0, 10
P 1C 126B0001  # beq  r19, r11, +1
P 1D 20140005  # addi r20, r0, 5
P 1E 8C150008  # lw   r21, 8(r0)
P 1F 16A10001  # bne  r21, r1, +1
P 20 20160006  # addi r22, r0, 6
P 21 20170007  # addi r23, r0, 7
P 22 FC000000  # halt
P 23 20180009  # addi r24, r0, 9
P 24 20190009  # addi r25, r0, 9
G
H
R 00 00000000
R 01 00000005
R 02 FFFFFFFD
R 03 00000002
R 04 00000008
R 05 00000005
R 06 FFFFFFFD
R 07 00000001
R 08 00000000
R 09 00000004
R 0A 00000009
R 0B 0000000A
R 0C 0000000D
R 0D 0000000D
R 0E 00000012
R 0F FFFFFFFD
R 10 00000000
R 11 00000002
R 12 00000000
R 13 0000000A
R 14 00000000
R 15 0000000D
R 16 00000000
R 17 00000007
R 18 00000000
R 19 00000000
M 02 0000000D
M 03 FFFFFFFD
M 04 00000012

/* sim.f */
hdl/cpuPkg.sv
hdl/pipeReg.sv
hdl/fetchStage.sv
hdl/regFile.sv
hdl/decodeStage.sv
hdl/executeStage.sv
hdl/memStage.sv
hdl/debugPort.sv
hdl/cpuTop.sv
testbench/cpuTb.sv

/* Bender.yml */
package:
  name: pipecpu

sources:
  - hdl/cpuPkg.sv
  - hdl/pipeReg.sv
  - hdl/fetchStage.sv
  - hdl/regFile.sv
  - hdl/decodeStage.sv
  - hdl/executeStage.sv
  - hdl/memStage.sv
  - hdl/debugPort.sv
  - hdl/cpuTop.sv
  - target: simulation
    files:
      - testbench/cpuTb.sv
